// ==== filelist.f ====
src/icache_pkg.sv
src/icache_way_if.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_top.sv
verif/icache_properties.sv
verif/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_icache

# assertion errors do not end the run early, the summary line still comes out
output=$(./obj_dir/Vtb_icache +verilator+error+limit+100 2>&1) || true
echo "$output"

if grep -qF '** PASS **' <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== src/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    // fetch side
    input  logic                                      i_rvalid,
    input  addr_t                                     i_raddr,
    output fetch_t                                    o_rdata,
    output logic                                      o_rdata_valid,
    output logic                                      o_idle,
    output logic                                      o_adef,
    output addr_t                                     o_badv,
    // memory side
    output logic                                      o_mem_rvalid,
    output addr_t                                     o_mem_raddr,
    output burst_len_t                                o_mem_rlen,
    input  logic                                      i_mem_rready,
    input  line_t                                     i_mem_rdata,
    // ways
    icache_way_if.ctrl                                way0,
    icache_way_if.ctrl                                way1,
    output logic [ADDR_W-LINE_OFS_W-INDEX_WIDTH-1:0] o_lookup_tag
);
    localparam int TAG_W = ADDR_W - LINE_OFS_W - INDEX_WIDTH;
    localparam int SETS  = 1 << INDEX_WIDTH;

    icache_state_t state;
    icache_state_t state_nxt;

    addr_t  req_buf;  // address under lookup
    line_t  ret_buf;  // line from memory
    logic [SETS-1:0] mru;  // 0: way0, 1: way1

    logic                   capture;
    logic                   misaligned;
    logic                   cache_hit;
    logic                   hit_way;
    logic                   fill_way;
    logic                   refill;
    logic [INDEX_WIDTH-1:0] req_index;
    logic [FETCH_SEL_W-1:0] fetch_sel;
    line_t                  sel_line;

    assign req_index  = req_buf[LINE_OFS_W +: INDEX_WIDTH];
    assign fetch_sel  = req_buf[FETCH_SEL_LSB +: FETCH_SEL_W];
    assign misaligned = (req_buf[ALIGN_W-1:0] != '0);
    assign refill     = (state == REFILL);

    // new request accepted when idle or while a response goes out
    assign capture = i_rvalid && (o_idle || o_rdata_valid);

    always_ff @(posedge clk) begin
        if (capture) begin
            req_buf <= i_raddr;
        end
    end

    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // way lookup, read index follows the raw request address
    assign way0.r_index = i_raddr[LINE_OFS_W +: INDEX_WIDTH];
    assign way1.r_index = i_raddr[LINE_OFS_W +: INDEX_WIDTH];
    assign o_lookup_tag = req_buf[ADDR_W-1 -: TAG_W];

    assign cache_hit = way0.hit || way1.hit;
    assign hit_way   = way1.hit;
    assign fill_way  = ~mru[req_index];  // replace the other one

    // refill write, same data to both, enable picks the way
    assign way0.w_index = req_index;
    assign way1.w_index = req_index;
    assign way0.w_tag   = req_buf[ADDR_W-1 -: TAG_W];
    assign way1.w_tag   = req_buf[ADDR_W-1 -: TAG_W];
    assign way0.w_line  = ret_buf;
    assign way1.w_line  = ret_buf;
    assign way0.we      = refill && !fill_way;
    assign way1.we      = refill && fill_way;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (state == LOOKUP && cache_hit && !misaligned) begin
            mru[req_index] <= hit_way;
        end else if (refill) begin
            mru[req_index] <= fill_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (capture) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (misaligned || cache_hit) begin
                    state_nxt = capture ? LOOKUP : IDLE;  // hits stream back to back
                end else begin
                    state_nxt = MISS;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                state_nxt = capture ? LOOKUP : IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // fetch word from the hitting way or from the returned line
    always_comb begin
        if (refill) begin
            sel_line = ret_buf;
        end else if (hit_way) begin
            sel_line = way1.r_line;
        end else begin
            sel_line = way0.r_line;
        end
    end

    assign o_rdata       = sel_line[fetch_sel*FETCH_W +: FETCH_W];
    assign o_rdata_valid = ((state == LOOKUP) && (misaligned || cache_hit)) || refill;
    assign o_idle        = (state == IDLE);
    assign o_adef        = (state == LOOKUP) && misaligned;
    assign o_badv        = req_buf;

    // one line request per miss
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = {req_buf[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
    assign o_mem_rlen   = REFILL_LEN;

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // address and bus widths
    localparam int ADDR_W  = 32;
    localparam int LINE_W  = 512;  // also the memory data width
    localparam int FETCH_W = 64;

    // address field positions
    localparam int LINE_OFS_W    = 6;  // byte offset in a line
    localparam int FETCH_SEL_W   = 3;
    localparam int FETCH_SEL_LSB = 3;  // fetch word select is addr[5:3]
    localparam int ALIGN_W       = 2;  // low bits that must be zero

    // sixteen beats as the memory side counts them
    localparam logic [7:0] REFILL_LEN = 8'd15;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [FETCH_W-1:0] fetch_t;
    typedef logic [7:0]         burst_len_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } icache_state_t;

endpackage

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic       clk,
    input  logic       rstn,
    // fetch side
    input  logic       i_rvalid,
    input  addr_t      i_raddr,
    output fetch_t     o_rdata,
    output logic       o_rdata_valid,
    output logic       o_idle,
    output logic       o_adef,
    output addr_t      o_badv,
    // memory side, one line per transfer
    output logic       o_mem_rvalid,
    output addr_t      o_mem_raddr,
    output burst_len_t o_mem_rlen,
    input  logic       i_mem_rready,
    input  line_t      i_mem_rdata
);
    logic [ADDR_W-LINE_OFS_W-INDEX_WIDTH-1:0] lookup_tag;  // shared by both ways

    icache_way_if #(.INDEX_WIDTH(INDEX_WIDTH)) way0_if ();
    icache_way_if #(.INDEX_WIDTH(INDEX_WIDTH)) way1_if ();

    icache_way #(.INDEX_WIDTH(INDEX_WIDTH)) way0_i (
        .clk          (clk),
        .rstn         (rstn),
        .way          (way0_if.way),
        .i_lookup_tag (lookup_tag)
    );

    icache_way #(.INDEX_WIDTH(INDEX_WIDTH)) way1_i (
        .clk          (clk),
        .rstn         (rstn),
        .way          (way1_if.way),
        .i_lookup_tag (lookup_tag)
    );

    icache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) ctrl_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_raddr       (i_raddr),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .o_idle        (o_idle),
        .o_adef        (o_adef),
        .o_badv        (o_badv),
        .o_mem_rvalid  (o_mem_rvalid),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata),
        .way0          (way0_if.ctrl),
        .way1          (way1_if.ctrl),
        .o_lookup_tag  (lookup_tag)
    );

endmodule

`default_nettype wire

// ==== src/icache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_way
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    icache_way_if.way                                 way,
    input  logic [ADDR_W-LINE_OFS_W-INDEX_WIDTH-1:0] i_lookup_tag
);
    localparam int TAG_W = ADDR_W - LINE_OFS_W - INDEX_WIDTH;
    localparam int SETS  = 1 << INDEX_WIDTH;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_mem [SETS];
    line_t            line_mem [SETS];

    logic             valid_rd;
    logic [TAG_W-1:0] tag_rd;
    line_t            line_rd;
    logic             bypass;

    // a fill and a lookup of the same set in one cycle
    // the lookup must see the new line, not the old one
    assign bypass = way.we && (way.w_index == way.r_index);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= '0;
            valid_rd <= 1'b0;
        end else begin
            if (way.we) begin
                valid_q[way.w_index] <= 1'b1;
            end
            valid_rd <= bypass || valid_q[way.r_index];
        end
    end

    // tag and line arrays, synchronous read
    always_ff @(posedge clk) begin
        if (way.we) begin
            tag_mem[way.w_index]  <= way.w_tag;
            line_mem[way.w_index] <= way.w_line;
        end
        if (bypass) begin
            tag_rd  <= way.w_tag;
            line_rd <= way.w_line;
        end else begin
            tag_rd  <= tag_mem[way.r_index];
            line_rd <= line_mem[way.r_index];
        end
    end

    assign way.hit    = valid_rd && (tag_rd == i_lookup_tag);
    assign way.r_line = line_rd;

endmodule

`default_nettype wire

// ==== src/icache_way_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one way's write port and lookup result
interface icache_way_if
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) ();
    localparam int TAG_W = ADDR_W - LINE_OFS_W - INDEX_WIDTH;

    logic [INDEX_WIDTH-1:0] r_index;  // from the incoming address
    logic [INDEX_WIDTH-1:0] w_index;
    logic                   we;
    logic [TAG_W-1:0]       w_tag;
    line_t                  w_line;
    logic                   hit;      // one cycle after r_index
    line_t                  r_line;

    modport way (input r_index, w_index, we, w_tag, w_line, output hit, r_line);

    modport ctrl (output r_index, w_index, we, w_tag, w_line, input hit, r_line);

endinterface

`default_nettype wire

// ==== verif/icache_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_properties
    import icache_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  o_mem_rvalid,
    input addr_t o_mem_raddr,
    input logic  i_mem_rready,
    input logic  o_rdata_valid
);
    int assert_fails = 0;  // failures seen so far

    // line request held with a fixed address until memory takes it
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_rvalid && !i_mem_rready) |=> (o_mem_rvalid && $stable(o_mem_raddr)))
    else begin
        $error("memory request dropped or changed before ready");
        assert_fails++;
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid |-> (o_mem_raddr[LINE_OFS_W-1:0] == '0))
    else begin
        $error("memory request address not line aligned");
        assert_fails++;
    end

    // blocking cache, nothing returned while a refill is pending
    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        !(o_mem_rvalid && o_rdata_valid))
    else begin
        $error("memory request and fetch response in the same cycle");
        assert_fails++;
    end

endmodule

bind icache_top icache_properties props_i (
    .clk           (clk),
    .rstn          (rstn),
    .o_mem_rvalid  (o_mem_rvalid),
    .o_mem_raddr   (o_mem_raddr),
    .i_mem_rready  (i_mem_rready),
    .o_rdata_valid (o_rdata_valid)
);

`default_nettype wire

// ==== verif/tb_icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();
    localparam int    TIMEOUT     = 50;  // cycles per wait
    localparam int    STREAM_LEN  = 20;
    localparam addr_t MEM_PATTERN = 32'h5a5a_0000;

    logic       clk = 1'b0;
    logic       rstn;
    logic       i_rvalid;
    addr_t      i_raddr;
    fetch_t     o_rdata;
    logic       o_rdata_valid;
    logic       o_idle;
    logic       o_adef;
    addr_t      o_badv;
    logic       o_mem_rvalid;
    addr_t      o_mem_raddr;
    burst_len_t o_mem_rlen;
    logic       i_mem_rready;
    line_t      i_mem_rdata;

    integer     seed;
    int         errors = 0;
    int         checks = 0;
    int         mem_reqs = 0;  // line requests seen by the responder
    int         delay;
    addr_t      last_mem_addr;
    burst_len_t last_mem_len;
    fetch_t     rd_data;  // results of the last fetch
    logic       rd_adef;
    addr_t      rd_badv;
    int         rd_lat;   // cycles from capture to response

    icache_top #(.INDEX_WIDTH(4)) dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_rvalid      (i_rvalid),
        .i_raddr       (i_raddr),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .o_idle        (o_idle),
        .o_adef        (o_adef),
        .o_badv        (o_badv),
        .o_mem_rvalid  (o_mem_rvalid),
        .o_mem_raddr   (o_mem_raddr),
        .o_mem_rlen    (o_mem_rlen),
        .i_mem_rready  (i_mem_rready),
        .i_mem_rdata   (i_mem_rdata)
    );

    always #20 clk = ~clk;

    // each 32-bit word of a line holds its own byte address XOR the pattern
    function automatic line_t mem_line(input addr_t base);
        line_t line;
        addr_t word;
        for (int i = 0; i < 16; i++) begin
            word = (base + i * 4) ^ MEM_PATTERN;
            line = {word, line[LINE_W-1:32]};  // word 0 ends up at the bottom
        end
        return line;
    endfunction

    // two adjacent words, the lower one at the 8-byte aligned address
    function automatic fetch_t expected_word(input addr_t addr);
        addr_t lo;
        lo = {addr[31:3], 3'b000};
        return {(lo + 32'd4) ^ MEM_PATTERN, lo ^ MEM_PATTERN};
    endfunction

    function automatic addr_t random_resident_addr();
        int    pick;
        addr_t base;
        pick = $unsigned($random(seed)) % 3;
        case (pick)
            0:       base = 32'h0000_2140;
            1:       base = 32'h0000_0400;
            default: base = 32'h0000_0800;
        endcase
        return base + (($unsigned($random(seed)) % 16) << 2);
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    // memory model, answers after 1 to 5 cycles
    always begin
        @(negedge clk);
        if (rstn && o_mem_rvalid) begin
            mem_reqs++;
            last_mem_addr = o_mem_raddr;
            last_mem_len  = o_mem_rlen;
            delay = 1 + ($unsigned($random(seed)) % 5);
            repeat (delay) @(posedge clk);
            #1;
            i_mem_rdata  = mem_line(o_mem_raddr);
            i_mem_rready = 1'b1;
            @(posedge clk);  // handshake edge
            #1;
            i_mem_rready = 1'b0;
        end
    end

    // single request, called 1 ns after a rising edge
    task automatic fetch(input addr_t addr);
        int waited;
        waited   = 0;
        i_rvalid = 1'b1;
        i_raddr  = addr;
        @(negedge clk);
        while (!(o_idle || o_rdata_valid) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            $display("request for %h was never accepted", addr);
            errors++;
        end
        @(posedge clk);  // capture
        #1;
        i_rvalid = 1'b0;
        rd_lat   = 0;
        do begin
            @(negedge clk);
            rd_lat++;
        end while (!o_rdata_valid && rd_lat < TIMEOUT);
        if (!o_rdata_valid) begin
            $display("no response for %h within %0d cycles", addr, TIMEOUT);
            errors++;
        end
        rd_data = o_rdata;
        rd_adef = o_adef;
        rd_badv = o_badv;
        @(posedge clk);
        #1;
    endtask

    task automatic fetch_and_compare(input addr_t addr, input int exp_reqs, input string what);
        int reqs0;
        reqs0 = mem_reqs;
        fetch(addr);
        check(64'(mem_reqs - reqs0), 64'(exp_reqs), {what, ": memory requests"});
        check(rd_data, expected_word(addr), {what, ": fetch word"});
        check(64'(rd_adef), 64'd0, {what, ": fault flag"});
    endtask

    task automatic after_reset();
        @(negedge clk);
        check(64'(o_idle), 64'd1, "reset: idle");
        check(64'(o_rdata_valid), 64'd0, "reset: response strobe");
        check(64'(o_mem_rvalid), 64'd0, "reset: memory request");
        check(64'(o_adef), 64'd0, "reset: fault flag");
        @(posedge clk);
        #1;
    endtask

    task automatic cold_miss();
        fetch_and_compare(32'h0000_2148, 1, "cold miss");
        check(64'(last_mem_addr), 64'h2140, "cold miss: line address");
        check(64'(last_mem_len), 64'd15, "cold miss: burst length");
    endtask

    task automatic hit_same_line();
        fetch_and_compare(32'h0000_2170, 0, "hit");
        check(64'(rd_lat), 64'd1, "hit: response one cycle after capture");
    endtask

    // A, B, C all in set 0
    task automatic replace_lru();
        fetch_and_compare(32'h0000_0404, 1, "replace: A first");
        fetch_and_compare(32'h0000_0810, 1, "replace: B first");
        fetch_and_compare(32'h0000_0418, 0, "replace: A again");
        fetch_and_compare(32'h0000_0c20, 1, "replace: C");
        fetch_and_compare(32'h0000_0438, 0, "replace: A kept");
        fetch_and_compare(32'h0000_083c, 1, "replace: B evicted");
    endtask

    task automatic misaligned_fault();
        int reqs0;
        reqs0 = mem_reqs;
        fetch(32'h0000_1282);  // set 10, line not resident
        check(64'(rd_adef), 64'd1, "fault: flag");
        check(64'(rd_badv), 64'h1282, "fault: bad address");
        check(64'(rd_lat), 64'd1, "fault: response in lookup cycle");
        check(64'(mem_reqs - reqs0), 64'd0, "fault: memory requests");
        @(negedge clk);
        check(64'(o_mem_rvalid), 64'd0, "fault: no line request follows");
        @(posedge clk);
        #1;
    endtask

    // request held valid, one new address per accepted cycle
    task automatic hit_stream();
        addr_t pending [$];
        int    sent;
        int    got;
        int    cycles;
        int    reqs0;
        logic  accept;
        reqs0    = mem_reqs;
        sent     = 0;
        got      = 0;
        cycles   = 0;
        i_rvalid = 1'b1;
        i_raddr  = random_resident_addr();
        while (got < STREAM_LEN && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            accept = i_rvalid && (o_idle || o_rdata_valid);
            if (o_rdata_valid) begin
                if (pending.size() == 0) begin
                    $display("stream: response with no request outstanding");
                    errors++;
                end else begin
                    check(o_rdata, expected_word(pending.pop_front()), "stream: fetch word");
                end
                got++;
            end
            @(posedge clk);
            #1;
            if (accept) begin
                pending.push_back(i_raddr);
                sent++;
                if (sent == STREAM_LEN) begin
                    i_rvalid = 1'b0;
                end else begin
                    i_raddr = random_resident_addr();
                end
            end
        end
        if (got < STREAM_LEN) begin
            $display("stream: only %0d of %0d responses before timeout", got, STREAM_LEN);
            errors++;
        end
        check(64'(cycles), 64'(STREAM_LEN + 1), "stream: one response per clock");
        check(64'(mem_reqs - reqs0), 64'd0, "stream: memory requests");
    endtask

    initial begin
        seed         = 32'hdabb_7d46;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        after_reset();
        cold_miss();
        hit_same_line();
        replace_lru();
        misaligned_fault();
        hit_stream();
        check(64'(dut_i.props_i.assert_fails), 64'd0, "assertion failures");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
